// File: build.f
src/axi_slave_pkg.sv
src/axi_burst_addr.sv
src/axi_sram.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_mem_slave.sv
sim/tb_clock.sv
sim/tb_axi_mem_slave.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the AXI memory slave testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_mem_slave \
    -f build.f \
    -o tb_axi_mem_slave
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/tb_axi_mem_slave
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation ended normally"
exit 0

// File: sim/tb_axi_mem_slave.sv
// Testbench for the AXI memory slave with a byte-array reference model and watchdog
module tb_axi_mem_slave;

    // Fill, INCR, strobe, WRAP and FIXED, back-pressure and WLAST beat counts
    localparam int PLANNED_BEATS   = 256 + 16 + 4 * 8 + 13 + 3 * 24 + 24;
    localparam int WATCHDOG_CYCLES = 20 * PLANNED_BEATS + 1000;

    logic                   clk;
    logic                   rst;
    axi_slave_pkg::axi_ax_t aw;
    logic                   aw_valid;
    logic                   aw_ready;
    axi_slave_pkg::axi_w_t  w;
    logic                   w_valid;
    logic                   w_ready;
    logic [1:0]             b_resp;
    logic                   b_valid;
    logic                   b_ready;
    axi_slave_pkg::axi_ax_t ar;
    logic                   ar_valid;
    logic                   ar_ready;
    axi_slave_pkg::axi_r_t  r;
    logic                   r_valid;
    logic                   r_ready;

    logic [7:0]             model_mem [2048];   // 2 KiB byte image of the RAM
    logic [31:0]            rng_state = 32'd32618;
    axi_slave_pkg::axi_r_t  r_q;
    logic                   r_wait_q;
    logic [1:0]             b_resp_q;
    logic                   b_wait_q;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    axi_mem_slave i_axi_mem_slave (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_resp   (b_resp),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] got);
        report_failure($sformatf("Error %s expected %h got %h", name, expected, got));
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic axi_slave_pkg::axi_ax_t make_request(input int unsigned addr, len,
                                                            size, input logic [1:0] burst);
        axi_slave_pkg::axi_ax_t req;
        req.addr  = 16'(addr);
        req.len   = 8'(len);
        req.size  = 3'(size);
        req.burst = burst;
        return req;
    endfunction

    // Address of beat n walked from the start one beat at a time
    function automatic int unsigned beat_address(input int unsigned addr, len, size,
                                                 input logic [1:0] burst,
                                                 input int unsigned n);
        int unsigned nbytes;
        int unsigned total;
        int unsigned low;
        int unsigned a;
        nbytes = 32'd1 << size;
        total  = (len + 1) * nbytes;
        low    = addr - (addr % total);   // Wrap window base
        a      = addr - (addr % nbytes);
        for (int unsigned i = 0; i < n; i++) begin
            if (burst == axi_slave_pkg::BURST_INCR || burst == axi_slave_pkg::BURST_WRAP) begin
                a = a + nbytes;
            end
            if (burst == axi_slave_pkg::BURST_WRAP && a >= low + total) begin
                a = low;
            end
        end
        return a;
    endfunction

    function automatic void update_model(input int unsigned a, input logic [63:0] data,
                                         input logic [7:0] strb);
        logic [63:0] bytes;
        logic [7:0]  lanes;
        logic [10:0] idx;
        bytes = data;
        lanes = strb;
        idx   = 11'(a & ~32'd7);   // Aliases every 2 KiB like the RAM
        for (int i = 0; i < 8; i++) begin
            if (lanes[0]) begin
                model_mem[idx] = bytes[7:0];
            end
            bytes = bytes >> 8;
            lanes = lanes >> 1;
            idx   = idx + 11'd1;
        end
    endfunction

    function automatic logic [63:0] model_word(input int unsigned a);
        logic [63:0] word;
        logic [10:0] idx;
        word = '0;
        idx  = 11'(a | 32'd7);   // Top byte first
        for (int i = 0; i < 8; i++) begin
            word = {word[55:0], model_mem[idx]};
            idx  = idx - 11'd1;
        end
        return word;
    endfunction

    task automatic write_burst(input int unsigned addr, len, size, input logic [1:0] burst,
                               input int unsigned last_at, input bit rand_strb, stall);
        int unsigned n;
        int unsigned a;
        logic [31:0] rnd;
        logic [31:0] lanes;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [1:0]  exp_resp;
        bit          pending;
        bit          done;
        exp_resp = (last_at == len) ? axi_slave_pkg::RESP_OKAY : axi_slave_pkg::RESP_SLVERR;
        @(negedge clk);
        aw       = make_request(addr, len, size, burst);
        aw_valid = 1'b1;
        while (!aw_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        aw_valid = 1'b0;
        n        = 0;
        pending  = 1'b0;
        while (n <= len) begin
            if (!pending) begin
                a     = beat_address(addr, len, size, burst, n);
                lanes = ((32'd1 << (32'd1 << size)) - 32'd1) << (a % 8);
                strb  = lanes[7:0];
                if (n == 0) begin
                    strb = strb & (8'hff << (addr % 8));   // Unaligned first beat
                end
                rnd = next_rand();
                if (rand_strb) begin
                    strb = strb & rnd[15:8];
                end
                data    = {next_rand(), next_rand()};
                w_valid = stall ? rnd[0] : 1'b1;
                w.data  = data;
                w.strb  = strb;
                w.last  = (n == last_at);
            end
            pending = w_valid && !w_ready;   // Payload held until accepted
            if (w_valid && w_ready) begin
                update_model(a, data, strb);
                n++;
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        assert (!w_ready) else report_failure("w_ready still high after the final write beat");
        if (stall) begin
            @(negedge clk);   // At least one cycle of B back-pressure
        end
        done = 1'b0;
        while (!done) begin
            rnd     = next_rand();
            b_ready = stall ? rnd[1] : 1'b1;
            if (b_valid && b_ready) begin
                assert (b_resp == exp_resp)
                    else report_mismatch("b_resp", 64'(exp_resp), 64'(b_resp));
                done = 1'b1;
            end
            @(negedge clk);
        end
        b_ready = 1'b0;
        assert (aw_ready) else report_failure("aw_ready did not return after the B response");
    endtask

    task automatic read_burst(input int unsigned addr, len, size, input logic [1:0] burst,
                              input bit stall);
        int unsigned n;
        logic [31:0] rnd;
        logic [63:0] exp_data;
        @(negedge clk);
        ar       = make_request(addr, len, size, burst);
        ar_valid = 1'b1;
        while (!ar_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        ar_valid = 1'b0;
        n        = 0;
        while (n <= len) begin
            rnd     = next_rand();
            r_ready = stall ? rnd[2] : 1'b1;
            if (r_valid && r_ready) begin
                exp_data = model_word(beat_address(addr, len, size, burst, n));
                assert (r.data == exp_data) else report_mismatch("r.data", exp_data, r.data);
                assert (r.last == (n == len))
                    else report_mismatch("r.last", 64'(n == len), 64'(r.last));
                assert (r.resp == axi_slave_pkg::RESP_OKAY)
                    else report_mismatch("r.resp", 64'(axi_slave_pkg::RESP_OKAY), 64'(r.resp));
                n++;
            end
            @(negedge clk);
        end
        r_ready = 1'b0;
        assert (ar_ready && !r_valid)
            else report_failure("read burst did not end after its last beat");
    endtask

    // Previous-edge view for the stability checks
    always @(posedge clk) begin
        r_q      <= r;
        r_wait_q <= r_valid && !r_ready;
        b_resp_q <= b_resp;
        b_wait_q <= b_valid && !b_ready;
    end

    assert property (@(posedge clk) disable iff (rst) r_wait_q |-> (r_valid && r == r_q))
        else report_failure("R beat changed while r_valid was high and r_ready low");

    assert property (@(posedge clk) disable iff (rst)
                     b_wait_q |-> (b_valid && b_resp == b_resp_q))
        else report_failure("B response dropped or changed before b_ready");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("Watchdog expired, the DUT stopped responding");
    end

    initial begin
        int unsigned base;
        int unsigned offset;
        int unsigned size;
        logic [31:0] rnd;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (aw_ready && ar_ready) else report_failure("aw_ready or ar_ready low after reset");
        assert (!b_valid && !r_valid) else report_failure("b_valid or r_valid high after reset");

        // Whole RAM gets known contents first
        write_burst(0, 255, 3, axi_slave_pkg::BURST_INCR, 255, 1'b0, 1'b0);

        write_burst(32'h100, 7, 3, axi_slave_pkg::BURST_INCR, 7, 1'b0, 1'b0);
        read_burst(32'h100, 7, 3, axi_slave_pkg::BURST_INCR, 1'b0);

        // Narrow and unaligned writes with random strobes
        for (int k = 0; k < 4; k++) begin
            rnd    = next_rand();
            base   = 32'h200 + 32'h20 * k;
            offset = 32'(rnd[2:0]);
            size   = 32'(rnd[9:8]) % 3;
            write_burst(base + offset, 3, size, axi_slave_pkg::BURST_INCR, 3, 1'b1, 1'b0);
            read_burst(base, 3, 3, axi_slave_pkg::BURST_INCR, 1'b0);
        end

        read_burst(32'h110, 3, 3, axi_slave_pkg::BURST_WRAP, 1'b0);   // Mid-window start
        write_burst(32'h300, 3, 3, axi_slave_pkg::BURST_FIXED, 3, 1'b0, 1'b0);
        read_burst(32'h2f8, 2, 3, axi_slave_pkg::BURST_INCR, 1'b0);
        read_burst(32'h108, 1, 3, 2'd3, 1'b0);   // Reserved type runs as FIXED

        // Write and read side by side under random back-pressure
        for (int k = 0; k < 3; k++) begin
            base = 32'h400 + 32'h40 * k;
            fork
                write_burst(base, 7, 3, axi_slave_pkg::BURST_INCR, 7, 1'b1, 1'b1);
                read_burst(32'h100, 7, 3, axi_slave_pkg::BURST_INCR, 1'b1);
            join
            read_burst(base, 7, 3, axi_slave_pkg::BURST_INCR, 1'b1);
        end

        write_burst(32'h500, 3, 3, axi_slave_pkg::BURST_INCR, 1, 1'b0, 1'b0);     // Early
        write_burst(32'h520, 3, 3, axi_slave_pkg::BURST_INCR, 999, 1'b0, 1'b0);   // Missing
        write_burst(32'h540, 3, 3, axi_slave_pkg::BURST_INCR, 3, 1'b0, 1'b0);
        read_burst(32'h500, 11, 3, axi_slave_pkg::BURST_INCR, 1'b0);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
// Testbench clock and reset source with a 10 unit period and reset held for 5 cycles
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;   // Released on a falling edge like all stimulus
    end

endmodule

// File: src/axi_mem_slave.sv
// AXI4 memory slave top joining write and read controllers to a shared RAM
module axi_mem_slave (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_slave_pkg::axi_ax_t  aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_slave_pkg::axi_w_t   w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output logic [1:0]              b_resp,
    output logic                    b_valid,
    input  logic                    b_ready,
    input  axi_slave_pkg::axi_ax_t  ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axi_slave_pkg::axi_r_t   r,
    output logic                    r_valid,
    input  logic                    r_ready
);

    axi_slave_pkg::mem_wr_t                 mem_wr;
    logic                                   mem_we;
    logic [axi_slave_pkg::WORD_IDX_W-1:0]   rd_idx;
    logic                                   rd_en;
    logic [axi_slave_pkg::DATA_W-1:0]       rd_data;

    axi_write_ctrl i_axi_write_ctrl (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_resp   (b_resp),
        .b_ready  (b_ready),
        .mem_wr   (mem_wr),
        .mem_we   (mem_we)
    );

    axi_read_ctrl i_axi_read_ctrl (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_data  (rd_data),
        .rd_idx   (rd_idx),
        .rd_en    (rd_en)
    );

    axi_sram i_axi_sram (
        .clk     (clk),
        .mem_we  (mem_we),
        .mem_wr  (mem_wr),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule

// File: src/axi_read_ctrl.sv
// AXI read controller fetching each beat from the RAM and presenting it on R
module axi_read_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  axi_slave_pkg::axi_ax_t              ar,
    input  logic                                ar_valid,
    output logic                                ar_ready,
    output axi_slave_pkg::axi_r_t               r,
    output logic                                r_valid,
    input  logic                                r_ready,
    input  logic [axi_slave_pkg::DATA_W-1:0]    rd_data,
    output logic [axi_slave_pkg::WORD_IDX_W-1:0] rd_idx,
    output logic                                rd_en
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PRESENT
    } state_t;

    state_t                             state;
    logic                               ar_hs;
    logic                               r_hs;
    logic                               next_beat;
    logic [axi_slave_pkg::ADDR_W-1:0]   beat_addr;
    logic                               last_beat;

    axi_burst_addr i_axi_burst_addr (
        .clk       (clk),
        .rst       (rst),
        .load      (ar_hs),
        .start     (ar),
        .advance   (next_beat),
        .beat_addr (beat_addr),
        .last_beat (last_beat)
    );

    assign ar_ready  = (state == ST_IDLE);
    assign r_valid   = (state == ST_PRESENT);
    assign ar_hs     = ar_valid & ar_ready;
    assign r_hs      = r_valid & r_ready;
    assign next_beat = r_hs & ~last_beat;

    assign rd_en  = (state == ST_FETCH);
    assign rd_idx = beat_addr[axi_slave_pkg::WORD_LSB +: axi_slave_pkg::WORD_IDX_W];

    // RAM output holds between fetches, so R stays stable under back-pressure
    always_comb begin
        r.data = rd_data;
        r.resp = axi_slave_pkg::RESP_OKAY;
        r.last = last_beat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (ar_hs) state <= ST_FETCH;
                ST_FETCH: state <= ST_PRESENT;   // Read data lands at this edge
                ST_PRESENT: begin
                    if (r_hs) state <= last_beat ? ST_IDLE : ST_FETCH;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: src/axi_write_ctrl.sv
// AXI write controller taking AW and W beats into the RAM and returning the B response
module axi_write_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_slave_pkg::axi_ax_t  aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_slave_pkg::axi_w_t   w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output logic                    b_valid,
    output logic [1:0]              b_resp,
    input  logic                    b_ready,
    output axi_slave_pkg::mem_wr_t  mem_wr,
    output logic                    mem_we
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t                                 state;
    logic                                   err;   // Sticky WLAST mismatch
    logic                                   aw_hs;
    logic                                   w_hs;
    logic                                   b_hs;
    logic [axi_slave_pkg::ADDR_W-1:0]       beat_addr;
    logic                                   last_beat;

    axi_burst_addr i_axi_burst_addr (
        .clk       (clk),
        .rst       (rst),
        .load      (aw_hs),
        .start     (aw),
        .advance   (w_hs),
        .beat_addr (beat_addr),
        .last_beat (last_beat)
    );

    assign aw_ready = (state == ST_IDLE);
    assign w_ready  = (state == ST_DATA);
    assign b_valid  = (state == ST_RESP);
    assign aw_hs    = aw_valid & aw_ready;
    assign w_hs     = w_valid & w_ready;
    assign b_hs     = b_valid & b_ready;

    assign b_resp = err ? axi_slave_pkg::RESP_SLVERR : axi_slave_pkg::RESP_OKAY;

    // RAM write goes out on the W handshake edge
    always_comb begin
        mem_wr.idx  = beat_addr[axi_slave_pkg::WORD_LSB +: axi_slave_pkg::WORD_IDX_W];
        mem_wr.data = w.data;
        mem_wr.be   = w.strb;
        mem_we      = w_hs;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            err   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (aw_hs) begin
                        state <= ST_DATA;
                        err   <= 1'b0;
                    end
                end
                ST_DATA: begin
                    if (w_hs) begin
                        if (w.last != last_beat) begin
                            err <= 1'b1;   // Early or missing WLAST
                        end
                        if (last_beat) begin
                            state <= ST_RESP;   // Beat count decides the end
                        end
                    end
                end
                ST_RESP: begin
                    if (b_hs) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: src/axi_sram.sv
// Word-wide RAM with per-byte write enables and a registered read port
module axi_sram (
    input  logic                                clk,
    input  logic                                mem_we,
    input  axi_slave_pkg::mem_wr_t              mem_wr,
    input  logic                                rd_en,
    input  logic [axi_slave_pkg::WORD_IDX_W-1:0] rd_idx,
    output logic [axi_slave_pkg::DATA_W-1:0]    rd_data
);

    logic [axi_slave_pkg::DATA_W-1:0] mem [axi_slave_pkg::MEM_WORDS];

    // One byte lane per enable bit
    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < axi_slave_pkg::STRB_W; i++) begin
                if (mem_wr.be[i]) begin
                    mem[mem_wr.idx][8*i +: 8] <= mem_wr.data[8*i +: 8];
                end
            end
        end
    end

    // Read before write on a shared word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// File: src/axi_burst_addr.sv
// AXI burst address generator giving beat address and last beat for FIXED, INCR and WRAP
module axi_burst_addr (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  axi_slave_pkg::axi_ax_t          start,
    input  logic                            advance,
    output logic [axi_slave_pkg::ADDR_W-1:0] beat_addr,
    output logic                            last_beat
);

    localparam int AW = axi_slave_pkg::ADDR_W;

    logic [AW-1:0]                     size_bytes;
    logic [AW-1:0]                     total_bytes;
    logic [AW-1:0]                     wrap_low;
    logic [AW-1:0]                     addr_q;
    logic [AW-1:0]                     size_q;
    logic [AW-1:0]                     low_q;
    logic [AW:0]                       high_q;   // Extra bit so a top-of-space window cannot overflow
    logic [AW:0]                       addr_sum;
    logic [axi_slave_pkg::LEN_W-1:0]   len_q;
    logic [axi_slave_pkg::LEN_W-1:0]   cnt_q;
    logic [1:0]                        burst_q;

    assign size_bytes  = AW'(1) << start.size;
    assign total_bytes = (AW'(start.len) + AW'(1)) << start.size;
    assign wrap_low    = start.addr & ~(total_bytes - AW'(1));
    assign addr_sum    = {1'b0, addr_q} + {1'b0, size_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q   <= '0;
            len_q   <= '0;
            burst_q <= axi_slave_pkg::BURST_FIXED;
        end else if (load) begin
            addr_q  <= start.addr & ~(size_bytes - AW'(1));   // Align to transfer size
            size_q  <= size_bytes;
            low_q   <= wrap_low;
            high_q  <= {1'b0, wrap_low} + {1'b0, total_bytes};
            len_q   <= start.len;
            burst_q <= start.burst;
            cnt_q   <= '0;
        end else if (advance) begin
            cnt_q <= cnt_q + 1'b1;
            case (burst_q)
                axi_slave_pkg::BURST_INCR: addr_q <= addr_sum[AW-1:0];
                axi_slave_pkg::BURST_WRAP: addr_q <= (addr_sum >= high_q) ? low_q : addr_sum[AW-1:0];
                default: addr_q <= addr_q;   // FIXED and reserved
            endcase
        end
    end

    assign beat_addr = addr_q;
    assign last_beat = (cnt_q == len_q);

endmodule

// File: src/axi_slave_pkg.sv
// AXI memory slave package with bus widths, burst and response codes, and channel structs
package axi_slave_pkg;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 64;
    localparam int STRB_W     = DATA_W / 8;   // One strobe per data byte
    localparam int LEN_W      = 8;
    localparam int MEM_WORDS  = 256;
    localparam int WORD_IDX_W = 8;
    localparam int WORD_LSB   = $clog2(STRB_W);   // Byte offset bits below the word index

    // Reserved burst code 3 runs as FIXED
    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] BURST_WRAP  = 2'd2;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // AW and AR request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;    // Beats minus one
        logic [2:0]        size;   // Log2 of bytes per beat
        logic [1:0]        burst;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // One RAM word write with byte lane enables
    typedef struct packed {
        logic [WORD_IDX_W-1:0] idx;
        logic [DATA_W-1:0]     data;
        logic [STRB_W-1:0]     be;
    } mem_wr_t;

endpackage
